// ==== source/isa_pkg.sv ====
package isa_pkg;

    // one data or instruction word
    typedef logic [15:0] word_t;

    // index into the eight general registers
    typedef logic [2:0] reg_idx_t;

    // alu function, low three bits of the function code
    typedef enum logic [2:0] {
        add_c  = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4,
        not_a  = 3'd5,
        inc_a  = 3'd6,
        dec_a  = 3'd7
    } alu_op_t;

    // jump condition, bits 13 to 12 of a jump
    typedef enum logic [1:0] {
        uncond = 2'd0,
        if_nz  = 2'd1,
        if_z   = 2'd2,
        never  = 2'd3
    } jmp_cond_t;

    // class nibble
    localparam int CLASS_HI = 15;
    localparam int CLASS_LO = 12;
    localparam logic [3:0] REG_CLASS = 4'b0111;
    localparam logic [3:0] NOP_CLASS = 4'b1111;

    // register class fields
    localparam int FUNC_HI = 11;
    localparam int FUNC_LO = 7;
    localparam logic [4:0] FUNC_MOV = 5'b11111;
    localparam logic [4:0] FUNC_INC = 5'b11110;
    localparam int ALU_OP_HI = 9;
    localparam int ALU_OP_LO = 7;
    localparam int DST_A_BIT = 6;
    localparam int OP1_HI = 5;
    localparam int OP1_LO = 3;
    localparam int OP2_HI = 2;
    localparam int OP2_LO = 0;

    // memory and jump class fields
    localparam int IND_BIT = 15;
    localparam int JMP_BIT = 14;
    localparam int STORE_BIT = 13;
    localparam int SEL_B_BIT = 12;
    localparam int COND_HI = 13;
    localparam int COND_LO = 12;
    localparam int ADDR_HI = 11;
    localparam int ADDR_LO = 0;

    // accumulators live in r0 and r1
    localparam reg_idx_t ACC_A_IDX = 3'd0;
    localparam reg_idx_t ACC_B_IDX = 3'd1;

endpackage

// ==== source/core_pkg.sv ====
package core_pkg;

    // microstep of the multicycle sequencer
    typedef enum logic [2:0] {
        fetch  = 3'd0,
        decode = 3'd1,
        exec1  = 3'd2,
        exec2  = 3'd3,
        exec3  = 3'd4
    } uop_t;

    // status left by the last alu operation
    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

    localparam flags_t FLAGS_CLEAR = '0;

endpackage

// ==== source/mem_if.sv ====
interface mem_if #(
    parameter int ADDR_W = 12
);
    import isa_pkg::*;

    // word address, low ADDR_W bits only
    logic [ADDR_W-1:0] addr;
    word_t wdata;
    // write strobe, taken on the rising edge
    logic we;
    // asynchronous read data for addr
    word_t rdata;

    // initiator side, drives the access
    modport core (output addr, output wdata, output we, input rdata);

    // target side, answers the access
    modport ram (input addr, input wdata, input we, output rdata);

endinterface

// ==== source/alu.sv ====
module alu (
    input  isa_pkg::alu_op_t op,
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    input  logic             carry_in,
    output isa_pkg::word_t   result,
    output logic             carry,
    output logic             zero
);
    import isa_pkg::*;

    // 17 bits so bit 16 holds carry or borrow
    logic [16:0] full;
    logic arith;

    always_comb
    begin
        case (op)
            // add with the stored carry
            add_c:
                full = {1'b0, a} + {1'b0, b} + {16'd0, carry_in};
            // bit 16 set means borrow
            sub:
                full = {1'b0, a} - {1'b0, b};
            and_op:
                full = {1'b0, a & b};
            or_op:
                full = {1'b0, a | b};
            xor_op:
                full = {1'b0, a ^ b};
            not_a:
                full = {1'b0, ~a};
            inc_a:
                full = {1'b0, a} + 17'd1;
            dec_a:
                full = {1'b0, a} - 17'd1;
            default:
                full = '0;
        endcase
    end

    // only the arithmetic functions report carry
    assign arith = (op == add_c) || (op == sub) || (op == inc_a) || (op == dec_a);

    assign result = full[15:0];
    assign carry = arith & full[16];
    assign zero = (full[15:0] == 16'd0);

endmodule

// ==== source/reg_file.sv ====
module reg_file (
    input  logic               CLK,
    input  logic               RST,
    input  isa_pkg::reg_idx_t  rd_idx_a,
    input  isa_pkg::reg_idx_t  rd_idx_b,
    input  isa_pkg::reg_idx_t  wr_idx,
    input  logic               wr_en,
    input  isa_pkg::word_t     wr_data,
    output isa_pkg::word_t     rd_a,
    output isa_pkg::word_t     rd_b,
    output isa_pkg::word_t     acc_a,
    output isa_pkg::word_t     acc_b
);
    import isa_pkg::*;

    // r0 is accumulator A, r1 is accumulator B
    word_t regs [8];

    always_ff @(posedge CLK)
    begin
        if (!RST)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // indexed reads see the value written on the last edge
    assign rd_a = regs[rd_idx_a];
    assign rd_b = regs[rd_idx_b];

    // fixed taps for the alu operands
    assign acc_a = regs[ACC_A_IDX];
    assign acc_b = regs[ACC_B_IDX];

endmodule

// ==== source/sequencer.sv ====
module sequencer #(
    parameter int ADDR_W = 12
) (
    input  logic CLK,
    input  logic RST,
    input  logic halt,
    output logic parked,
    mem_if.core  mem
);
    import isa_pkg::*;
    import core_pkg::*;

    typedef logic [ADDR_W-1:0] addr_t;

    // address field must fit the RAM address
    if (ADDR_W < 8 || ADDR_W > ADDR_HI - ADDR_LO + 1)
    begin : g_addr_w_check
        $error("sequencer: ADDR_W out of range 8 to 12");
    end

    uop_t uop;
    addr_t pc;
    addr_t mar;
    word_t ir;
    flags_t flags;

    // decoded view of ir
    logic is_reg;
    logic is_nop;
    logic is_mem;
    logic is_mov;
    logic is_inc;
    logic is_alu;
    logic is_ind;
    logic is_jmp;
    logic is_ldst;
    logic is_store;
    logic take_jmp;
    logic done1;
    logic done2;
    logic data_step;
    reg_idx_t op1;
    reg_idx_t op2;
    reg_idx_t acc_idx;
    addr_t ir_addr;

    // datapath
    logic rf_we;
    reg_idx_t rf_widx;
    word_t rf_wdata;
    word_t rd_a;
    word_t rd_b;
    word_t acc_a;
    word_t acc_b;
    word_t alu_res;
    logic alu_carry;
    logic alu_zero;

    assign is_reg = (ir[CLASS_HI:CLASS_LO] == REG_CLASS);
    assign is_nop = (ir[CLASS_HI:CLASS_LO] == NOP_CLASS);
    assign is_mem = !is_reg && !is_nop;
    assign is_mov = is_reg && (ir[FUNC_HI:FUNC_LO] == FUNC_MOV);
    assign is_inc = is_reg && (ir[FUNC_HI:FUNC_LO] == FUNC_INC);
    assign is_alu = is_reg && !is_mov && !is_inc;
    assign is_ind = ir[IND_BIT];
    assign is_jmp = is_mem && ir[JMP_BIT];
    assign is_ldst = is_mem && !ir[JMP_BIT];
    assign is_store = is_ldst && ir[STORE_BIT];
    assign op1 = ir[OP1_HI:OP1_LO];
    assign op2 = ir[OP2_HI:OP2_LO];
    // bit 12 picks B for load and store
    assign acc_idx = ir[SEL_B_BIT] ? ACC_B_IDX : ACC_A_IDX;
    assign ir_addr = ir[ADDR_LO +: ADDR_W];

    always_comb
    begin
        case (jmp_cond_t'(ir[COND_HI:COND_LO]))
            uncond:
                take_jmp = 1'b1;
            if_nz:
                take_jmp = !flags.zero;
            if_z:
                take_jmp = flags.zero;
            never:
                take_jmp = 1'b0;
            default:
                take_jmp = 1'b0;
        endcase
    end

    // 3 cycle group ends in exec1, 4 cycle group in exec2
    assign done1 = is_mov || is_inc || is_nop || (is_jmp && !is_ind);
    assign done2 = is_mem && (is_jmp || !is_ind);

    // step where a load or store touches its operand
    assign data_step = is_ldst && ((uop == exec2 && !is_ind) || (uop == exec3 && is_ind));

    always_comb
    begin
        rf_we = 1'b0;
        rf_widx = acc_idx;
        rf_wdata = mem.rdata;
        if (uop == exec1 && (is_mov || is_inc))
        begin
            // rd gets rs, or rd plus one
            rf_we = 1'b1;
            rf_widx = op1;
            rf_wdata = is_mov ? rd_b : rd_a + 16'd1;
        end
        else if (uop == exec1 && is_alu && op1 != ACC_A_IDX)
        begin
            rf_we = 1'b1;
            rf_widx = ACC_A_IDX;
            rf_wdata = rd_a;
        end
        else if (uop == exec2 && is_alu && op2 != ACC_B_IDX)
        begin
            // read after exec1, so op2 of r0 sees the new A
            rf_we = 1'b1;
            rf_widx = ACC_B_IDX;
            rf_wdata = rd_b;
        end
        else if (uop == exec3 && is_alu)
        begin
            rf_we = 1'b1;
            rf_widx = ir[DST_A_BIT] ? ACC_A_IDX : ACC_B_IDX;
            rf_wdata = alu_res;
        end
        else if (data_step && !is_store)
        begin
            rf_we = 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RST)
        begin
            uop <= fetch;
            pc <= '0;
            flags <= FLAGS_CLEAR;
        end
        else
        begin
            case (uop)
                fetch:
                begin
                    // hold here while the host owns the RAM
                    if (!halt)
                    begin
                        mar <= pc;
                        pc <= pc + 1'b1;
                        uop <= decode;
                    end
                end
                decode:
                begin
                    ir <= mem.rdata;
                    uop <= exec1;
                end
                exec1:
                begin
                    if (is_mem)
                    begin
                        mar <= ir_addr;
                    end
                    if (is_jmp && !is_ind && take_jmp)
                    begin
                        pc <= ir_addr;
                    end
                    uop <= done1 ? fetch : exec2;
                end
                exec2:
                begin
                    // indirect jump target or pointer from RAM[addr]
                    if (is_jmp && is_ind && take_jmp)
                    begin
                        pc <= mem.rdata[ADDR_W-1:0];
                    end
                    if (is_ldst && is_ind)
                    begin
                        mar <= mem.rdata[ADDR_W-1:0];
                    end
                    uop <= done2 ? fetch : exec3;
                end
                exec3:
                begin
                    if (is_alu)
                    begin
                        flags <= '{zero: alu_zero, carry: alu_carry};
                    end
                    uop <= fetch;
                end
                default:
                    uop <= fetch;
            endcase
        end
    end

    assign parked = (uop == fetch) && halt;

    // RAM always addressed through mar
    assign mem.addr = mar;
    assign mem.wdata = ir[SEL_B_BIT] ? acc_b : acc_a;
    assign mem.we = data_step && is_store;

    reg_file u_reg_file (
        .CLK      (CLK),
        .RST      (RST),
        .rd_idx_a (op1),
        .rd_idx_b (op2),
        .wr_idx   (rf_widx),
        .wr_en    (rf_we),
        .wr_data  (rf_wdata),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .acc_a    (acc_a),
        .acc_b    (acc_b)
    );

    alu u_alu (
        .op       (alu_op_t'(ir[ALU_OP_HI:ALU_OP_LO])),
        .a        (acc_a),
        .b        (acc_b),
        .carry_in (flags.carry),
        .result   (alu_res),
        .carry    (alu_carry),
        .zero     (alu_zero)
    );

    // state register only ever holds one of the five steps
    a_uop_legal: assert property (@(posedge CLK) disable iff (!RST)
        uop inside {fetch, decode, exec1, exec2, exec3});

    // a write is the last step of its instruction, fetch follows
    a_we_final_store: assert property (@(posedge CLK) disable iff (!RST)
        mem.we |=> (uop == fetch));

endmodule

// ==== source/host_port.sv ====
module host_port #(
    parameter int ADDR_W = 12
) (
    input  logic           CLK,
    input  logic           RST,
    input  logic           HALT,
    output logic           parked,
    input  logic           core_parked,
    input  isa_pkg::word_t data,
    input  isa_pkg::word_t address,
    input  logic           ext_ram_rw,
    input  logic           ext_ram_en,
    output isa_pkg::word_t out,
    output logic           halted,
    // core faces the sequencer, ram faces word_ram
    mem_if.ram             core,
    mem_if.core            ram
);
    logic host_wr;
    logic host_rd;

    // halted is parked seen one edge later
    always_ff @(posedge CLK)
    begin
        if (!RST)
        begin
            halted <= 1'b0;
        end
        else
        begin
            halted <= core_parked;
        end
    end

    // park request to the core, held through a host strobe
    assign parked = HALT || (halted && ext_ram_en);

    // host strobes count only once halted
    assign host_wr = halted && ext_ram_en && ext_ram_rw;
    assign host_rd = halted && ext_ram_en && !ext_ram_rw;

    always_comb
    begin
        if (halted)
        begin
            ram.addr = address[ADDR_W-1:0];
            ram.wdata = data;
            ram.we = host_wr;
        end
        else
        begin
            ram.addr = core.addr;
            ram.wdata = core.wdata;
            ram.we = core.we;
        end
    end

    assign core.rdata = ram.rdata;

    // readback held until the next read
    always_ff @(posedge CLK)
    begin
        if (!RST)
        begin
            out <= '0;
        end
        else if (host_rd)
        begin
            out <= ram.rdata;
        end
    end

    // core is in fetch whenever halted, so it cannot be storing
    a_no_core_we_halted: assert property (@(posedge CLK) disable iff (!RST)
        halted |-> !core.we);

endmodule

// ==== source/word_ram.sv ====
module word_ram #(
    parameter int ADDR_W = 12
) (
    input logic CLK,
    mem_if.ram  bus
);
    import isa_pkg::*;

    // program and data share one array
    word_t mem [1 << ADDR_W];

    // write on the edge where we is high
    always_ff @(posedge CLK)
    begin
        if (bus.we)
        begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // combinational read, follows addr in the same cycle
    assign bus.rdata = mem[bus.addr];

endmodule

// ==== source/cpu_top.sv ====
module cpu_top #(
    parameter int ADDR_W = 12
) (
    input  logic           CLK,
    input  logic           RST,
    input  logic           HALT,
    input  logic           EXT_RAM_RW,
    input  logic           EXT_RAM_EN,
    input  isa_pkg::word_t DATA,
    input  isa_pkg::word_t ADDRESS,
    output isa_pkg::word_t OUT,
    output logic           HALTED
);
    // park request down, parked status up
    logic park_req;
    logic core_parked;

    // sequencer to arbiter, arbiter to RAM
    mem_if #(.ADDR_W(ADDR_W)) core_bus ();
    mem_if #(.ADDR_W(ADDR_W)) ram_bus ();

    sequencer #(.ADDR_W(ADDR_W)) u_sequencer (
        .CLK    (CLK),
        .RST    (RST),
        .halt   (park_req),
        .parked (core_parked),
        .mem    (core_bus.core)
    );

    host_port #(.ADDR_W(ADDR_W)) u_host_port (
        .CLK         (CLK),
        .RST         (RST),
        .HALT        (HALT),
        .parked      (park_req),
        .core_parked (core_parked),
        .data        (DATA),
        .address     (ADDRESS),
        .ext_ram_rw  (EXT_RAM_RW),
        .ext_ram_en  (EXT_RAM_EN),
        .out         (OUT),
        .halted      (HALTED),
        .core        (core_bus.ram),
        .ram         (ram_bus.core)
    );

    word_ram #(.ADDR_W(ADDR_W)) u_word_ram (
        .CLK (CLK),
        .bus (ram_bus.ram)
    );

endmodule

// ==== sim/cpu_checker.sv ====
module cpu_checker (
    input  logic        CLK,
    input  logic        RST,
    input  logic        halt,
    input  logic        ext_ram_rw,
    input  logic        ext_ram_en,
    input  logic [15:0] data,
    input  logic [15:0] address,
    input  logic [15:0] out,
    input  logic        halted,
    output int          mismatches,
    output int          model_faults,
    output int          reads_checked
);
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;

    localparam int STEP_LIMIT = 2000;

    // programmer's view of the machine
    logic [15:0] mem [4096];
    logic [15:0] regs [8];
    logic [11:0] pc;
    logic        zero_flag;
    logic        carry_flag;

    // host read waiting for its OUT cycle
    logic        read_pending;
    logic [11:0] read_addr;
    logic [15:0] read_expect;
    logic        halt_seen;

    // 17 bit result, bit 16 is carry or borrow
    function automatic logic [16:0] alu_result(input logic [2:0] op, input logic [15:0] a,
                                               input logic [15:0] b, input logic cin);
        case (op)
            add_c:
                return {1'b0, a} + {1'b0, b} + {16'd0, cin};
            sub:
                return {1'b0, a} - {1'b0, b};
            and_op:
                return {1'b0, a & b};
            or_op:
                return {1'b0, a | b};
            xor_op:
                return {1'b0, a ^ b};
            not_a:
                return {1'b0, ~a};
            inc_a:
                return {1'b0, a} + 17'd1;
            default:
                return {1'b0, a} - 17'd1;
        endcase
    endfunction

    task automatic reset_model();
        pc = '0;
        zero_flag = 1'b0;
        carry_flag = 1'b0;
        for (int k = 0; k < 8; k++)
        begin
            regs[k] = '0;
        end
    endtask

    task automatic execute_one();
        logic [15:0] ir;
        logic [11:0] ea;
        logic [16:0] res;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic        take;
        ir = mem[pc];
        pc = pc + 12'd1;
        rd = ir[OP1_HI:OP1_LO];
        rs = ir[OP2_HI:OP2_LO];
        ea = ir[ADDR_HI:ADDR_LO];
        if (ir[CLASS_HI:CLASS_LO] == REG_CLASS)
        begin
            if (ir[FUNC_HI:FUNC_LO] == FUNC_MOV)
            begin
                regs[rd] = regs[rs];
            end
            else if (ir[FUNC_HI:FUNC_LO] == FUNC_INC)
            begin
                regs[rd] = regs[rd] + 16'd1;
            end
            else
            begin
                // A gets op1 first, so op2 of r0 sees the new A
                if (rd != 3'd0)
                begin
                    regs[0] = regs[rd];
                end
                if (rs != 3'd1)
                begin
                    regs[1] = regs[rs];
                end
                res = alu_result(ir[ALU_OP_HI:ALU_OP_LO], regs[0], regs[1], carry_flag);
                if (ir[DST_A_BIT])
                begin
                    regs[0] = res[15:0];
                end
                else
                begin
                    regs[1] = res[15:0];
                end
                zero_flag = (res[15:0] == 16'd0);
                carry_flag = res[16];
            end
        end
        else if (ir[CLASS_HI:CLASS_LO] != NOP_CLASS)
        begin
            // indirect forms go through a pointer word
            if (ir[IND_BIT])
            begin
                ea = mem[ir[ADDR_HI:ADDR_LO]][11:0];
            end
            if (ir[JMP_BIT])
            begin
                case (ir[COND_HI:COND_LO])
                    2'b00:
                        take = 1'b1;
                    2'b01:
                        take = !zero_flag;
                    2'b10:
                        take = zero_flag;
                    default:
                        take = 1'b0;
                endcase
                if (take)
                begin
                    pc = ea;
                end
            end
            else if (ir[STORE_BIT])
            begin
                mem[ea] = regs[{2'b00, ir[SEL_B_BIT]}];
            end
            else
            begin
                regs[{2'b00, ir[SEL_B_BIT]}] = mem[ea];
            end
        end
    endtask

    // runs until pc sits on a jump to itself
    task automatic run_program();
        int          steps;
        logic [15:0] ir;
        logic        parked_loop;
        steps = 0;
        ir = mem[pc];
        parked_loop = (ir[15:12] === 4'b0100) && (ir[11:0] === pc);
        while (!parked_loop && steps < STEP_LIMIT)
        begin
            execute_one();
            steps++;
            ir = mem[pc];
            parked_loop = (ir[15:12] === 4'b0100) && (ir[11:0] === pc);
        end
        if (!parked_loop)
        begin
            $display("ERROR: reference model ran %0d steps without reaching the self-jump",
                     STEP_LIMIT);
            model_faults++;
        end
    endtask

    initial
    begin
        mismatches = 0;
        model_faults = 0;
        reads_checked = 0;
        read_pending = 1'b0;
        read_addr = '0;
        read_expect = '0;
        halt_seen = 1'b1;
        reset_model();
        forever
        begin
            // inputs and OUT are both settled at the falling edge
            @(negedge CLK);
            if (read_pending)
            begin
                reads_checked++;
                if (out !== read_expect)
                begin
                    $display("FAIL time %0t signal OUT addr %h expected %h actual %h",
                             $time, read_addr, read_expect, out);
                    mismatches++;
                end
                read_pending = 1'b0;
            end
            // strobe the coming edge will honor
            if (halted === 1'b1 && ext_ram_en === 1'b1)
            begin
                if (ext_ram_rw)
                begin
                    mem[address[11:0]] = data;
                end
                else
                begin
                    read_addr = address[11:0];
                    read_expect = mem[address[11:0]];
                    read_pending = 1'b1;
                end
            end
            if (!RST)
            begin
                reset_model();
            end
            else if (halt_seen && !halt)
            begin
                run_program();
            end
            halt_seen = halt;
        end
    end

endmodule

// ==== sim/cpu_tb.sv ====
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;

    localparam int RUNS = 8;
    localparam int PROG_LEN = 40;

    logic        CLK;
    logic        RST;
    logic        halt;
    logic        ext_ram_rw;
    logic        ext_ram_en;
    logic [15:0] data;
    logic [15:0] address;
    logic [15:0] out;
    logic        halted;

    logic [31:0] lfsr;
    int          timeouts;
    int          budget;
    int          mismatches;
    int          model_faults;
    int          reads_checked;

    cpu_top #(.ADDR_W(12)) DUT (
        .CLK        (CLK),
        .RST        (RST),
        .HALT       (halt),
        .EXT_RAM_RW (ext_ram_rw),
        .EXT_RAM_EN (ext_ram_en),
        .DATA       (data),
        .ADDRESS    (address),
        .OUT        (out),
        .HALTED     (halted)
    );

    cpu_checker u_checker (
        .CLK           (CLK),
        .RST           (RST),
        .halt          (halt),
        .ext_ram_rw    (ext_ram_rw),
        .ext_ram_en    (ext_ram_en),
        .data          (data),
        .address       (address),
        .out           (out),
        .halted        (halted),
        .mismatches    (mismatches),
        .model_faults  (model_faults),
        .reads_checked (reads_checked)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #4 CLK = ~CLK;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] draw_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic set_halt(input logic level);
        @(posedge CLK);
        #1;
        halt = level;
    endtask

    task automatic host_write(input logic [15:0] addr, input logic [15:0] value);
        @(posedge CLK);
        #1;
        ext_ram_en = 1'b1;
        ext_ram_rw = 1'b1;
        address = addr;
        data = value;
    endtask

    task automatic host_read(input logic [15:0] addr);
        @(posedge CLK);
        #1;
        ext_ram_en = 1'b1;
        ext_ram_rw = 1'b0;
        address = addr;
    endtask

    task automatic host_idle();
        @(posedge CLK);
        #1;
        ext_ram_en = 1'b0;
        ext_ram_rw = 1'b0;
    endtask

    task automatic wait_halted(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (halted !== level && n < limit)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (halted !== level)
        begin
            $display("ERROR: timed out after %0d cycles waiting for %s", limit, what);
            timeouts++;
        end
    endtask

    // data, pointer tables and a random program, with a cycle budget
    task automatic load_program();
        logic [15:0] instr;
        logic [15:0] target;
        logic [15:0] cond;
        logic [15:0] kind;
        budget = 10;
        for (int k = 0; k < 64; k++)
        begin
            host_write(16'h0800 + 16'(k), draw_bits(16));
        end
        // pointers stay inside the data region
        for (int k = 0; k < 8; k++)
        begin
            host_write(16'h0840 + 16'(k), 16'h0800 + draw_bits(6));
        end
        for (int k = 0; k < 4; k++)
        begin
            host_write(16'h0860 + 16'(k), draw_bits(16));
        end
        for (int i = 0; i < PROG_LEN - 1; i++)
        begin
            kind = draw_bits(3);
            // forward target, never past the closing self-jump
            target = 16'(i + 1) + draw_bits(2);
            if (target > 16'(PROG_LEN - 1))
            begin
                target = 16'(PROG_LEN - 1);
            end
            cond = draw_bits(2);
            case (kind)
                16'd0, 16'd1:
                begin
                    instr = {REG_CLASS, 12'h000} | draw_bits(10);
                    budget += 5;
                end
                16'd2:
                begin
                    instr = {REG_CLASS, FUNC_MOV, 7'd0} | draw_bits(6);
                    budget += 3;
                end
                16'd3:
                begin
                    if (draw_bits(2) == 16'd0)
                    begin
                        instr = {NOP_CLASS, 12'h000} | draw_bits(12);
                    end
                    else
                    begin
                        instr = {REG_CLASS, FUNC_INC, 7'd0} | draw_bits(6);
                    end
                    budget += 3;
                end
                16'd4:
                begin
                    instr = (draw_bits(2) << 12) | 16'h0800 | draw_bits(6);
                    budget += 4;
                end
                16'd5:
                begin
                    instr = 16'h8000 | (draw_bits(2) << 12) | 16'h0840 | draw_bits(3);
                    budget += 5;
                end
                16'd6:
                begin
                    // cond 11 would alias the register class
                    if (cond == 16'd3)
                    begin
                        cond = 16'd0;
                    end
                    instr = 16'h4000 | (cond << 12) | target;
                    budget += 3;
                end
                default:
                begin
                    // one table slot per jump, cond 11 is never taken
                    host_write(16'h0850 + 16'(i), target);
                    instr = 16'hC000 | (cond << 12) | (16'h0850 + 16'(i));
                    budget += 4;
                end
            endcase
            host_write(16'(i), instr);
        end
        host_write(16'(PROG_LEN - 1), 16'h4000 | 16'(PROG_LEN - 1));
    endtask

    initial
    begin
        int mid;
        RST = 1'b0;
        halt = 1'b1;
        ext_ram_rw = 1'b0;
        ext_ram_en = 1'b0;
        data = '0;
        address = '0;
        lfsr = 32'h7370_d20b;
        timeouts = 0;
        for (int run = 0; run < RUNS; run++)
        begin
            // reset with halt held so the core parks in fetch
            @(posedge CLK);
            #1;
            RST = 1'b0;
            halt = 1'b1;
            repeat (5) @(posedge CLK);
            #1;
            RST = 1'b1;
            wait_halted(1'b1, 10, "HALTED after reset");
            load_program();
            host_idle();
            set_halt(1'b0);
            wait_halted(1'b0, 4, "HALTED to fall after release");
            // strobes while running must not reach the RAM
            for (int k = 0; k < 4; k++)
            begin
                host_write(16'h0860 + 16'(k), draw_bits(16));
            end
            host_idle();
            // park mid-program, then resume
            mid = int'(draw_bits(6));
            repeat (mid) @(posedge CLK);
            set_halt(1'b1);
            wait_halted(1'b1, 8, "HALTED after a mid-run halt");
            repeat (3) @(posedge CLK);
            set_halt(1'b0);
            wait_halted(1'b0, 4, "HALTED to fall on resume");
            repeat (budget) @(posedge CLK);
            set_halt(1'b1);
            wait_halted(1'b1, 8, "HALTED at the end of a run");
            for (int k = 0; k < 64; k++)
            begin
                host_read(16'h0800 + 16'(k));
            end
            for (int k = 0; k < 4; k++)
            begin
                host_read(16'h0860 + 16'(k));
            end
            host_idle();
        end
        repeat (3) @(posedge CLK);
        $display("errors: %0d mismatches, %0d model faults, %0d timeouts, %0d reads checked",
                 mismatches, model_faults, timeouts, reads_checked);
        if (mismatches == 0 && model_faults == 0 && timeouts == 0 && reads_checked > 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== cpu_top.f ====
source/isa_pkg.sv
source/core_pkg.sv
source/mem_if.sv
source/alu.sv
source/reg_file.sv
source/sequencer.sv
source/host_port.sv
source/word_ram.sv
source/cpu_top.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - source/isa_pkg.sv
  - source/core_pkg.sv
  - source/mem_if.sv
  - source/alu.sv
  - source/reg_file.sv
  - source/sequencer.sv
  - source/host_port.sv
  - source/word_ram.sv
  - source/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_checker.sv
      - sim/cpu_tb.sv
